// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  // Bus geometry
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int SEL_W     = DATA_W / 8;
  localparam int NR_MASTER = 2;  // m0 is the CPU port, m1 the DMA port
  localparam int NR_SLAVE  = 3;

  // Address map, sizes in bytes
  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] RAM_SIZE  = 32'h0000_0400;
  localparam int                RAM_WORDS = RAM_SIZE / SEL_W;

  localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] GPIO_SIZE = 32'h0000_0010;
  localparam int                GPIO_W    = 8;

  localparam logic [ADDR_W-1:0] RST_BASE = 32'h1000_0030;
  localparam logic [ADDR_W-1:0] RST_SIZE = 32'h0000_0004;  // One word only

  // Reset sequencing
  localparam int POR_CYCLES       = 16;  // Hold after reset and lock are both good
  localparam int NDM_PULSE_CYCLES = 16;
  localparam int SYNC_STAGES      = 2;

  typedef enum logic [1:0] {
    NONE     = 2'd0,
    POWER_ON = 2'd1,
    PLL_LOSS = 2'd2,
    SOFTWARE = 2'd3
  } rst_reason_e;

  // Reset controller word, written and read with different layouts
  typedef union packed {
    struct packed {
      logic [DATA_W-2:0] rsvd;
      logic              ndm_req;  // Request a non-debug reset pulse
    } wr;
    struct packed {
      logic [DATA_W-4:0] zero;
      rst_reason_e       reason;   // Cause of the most recent reset
      logic              por_completed;
    } rd;
  } rst_word_u;

endpackage

// ==== hdl/bus_arbiter.sv ====
module bus_arbiter import soc_pkg::*; (
  input  logic                 sys_clk,
  input  logic                 rst_n_i,
  input  logic [NR_MASTER-1:0] m_cyc_i,
  output logic [NR_MASTER-1:0] grant_o,
  output logic                 bus_busy_o
);

  logic [NR_MASTER-1:0] grant_q;
  logic [NR_MASTER-1:0] next_gnt;
  logic                 holder_active;

  assign holder_active = |(grant_q & m_cyc_i);

  // Lowest index wins, so scan downwards and let the last hit stand
  always_comb begin
    next_gnt = '0;
    for (int i = NR_MASTER - 1; i >= 0; i--) begin
      if (m_cyc_i[i]) next_gnt = NR_MASTER'(1) << i;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      grant_q <= '0;
    end else if (!holder_active) begin
      grant_q <= next_gnt;  // Hand over as soon as the holder lets go
    end
  end

  assign grant_o    = grant_q;
  assign bus_busy_o = |grant_q;

  a_grant_onehot: assert property (
    @(posedge sys_clk) disable iff (!rst_n_i)
    $onehot0(grant_q)
  );

endmodule

// ==== hdl/shared_bus.sv ====
module shared_bus import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n_i,
  // CPU master port
  input  logic              m0_cyc_i,
  input  logic              m0_stb_i,
  input  logic              m0_we_i,
  input  logic [ADDR_W-1:0] m0_adr_i,
  input  logic [DATA_W-1:0] m0_dat_i,
  input  logic [SEL_W-1:0]  m0_sel_i,
  output logic              m0_stall_o,
  output logic              m0_ack_o,
  output logic              m0_err_o,
  output logic [DATA_W-1:0] m0_dat_o,
  // DMA master port
  input  logic              m1_cyc_i,
  input  logic              m1_stb_i,
  input  logic              m1_we_i,
  input  logic [ADDR_W-1:0] m1_adr_i,
  input  logic [DATA_W-1:0] m1_dat_i,
  input  logic [SEL_W-1:0]  m1_sel_i,
  output logic              m1_stall_o,
  output logic              m1_ack_o,
  output logic              m1_err_o,
  output logic [DATA_W-1:0] m1_dat_o,
  // Shared slave side
  output logic              sl_cyc_o,
  output logic              sl_we_o,
  output logic [ADDR_W-1:0] sl_adr_o,
  output logic [DATA_W-1:0] sl_dat_o,
  output logic [SEL_W-1:0]  sl_sel_o,
  output logic              ram_stb_o,
  output logic              gpio_stb_o,
  output logic              rst_stb_o,
  input  logic              ram_ack_i,
  input  logic [DATA_W-1:0] ram_dat_i,
  input  logic              gpio_ack_i,
  input  logic [DATA_W-1:0] gpio_dat_i,
  input  logic              rst_ack_i,
  input  logic [DATA_W-1:0] rst_dat_i
);

  logic [NR_MASTER-1:0] grant;
  logic                 bus_busy;
  logic                 gnt_stb;
  logic [NR_SLAVE-1:0]  hit;       // 0 RAM, 1 GPIO, 2 reset controller
  logic                 err_q;
  logic                 ack_any;
  logic [DATA_W-1:0]    rd_dat;

  function automatic logic in_window(logic [ADDR_W-1:0] adr, logic [ADDR_W-1:0] base,
                                     logic [ADDR_W-1:0] size);
    logic [ADDR_W-1:0] offs;
    offs = adr - base;  // Wraps below base, so one compare covers both ends
    return offs < size;
  endfunction

  bus_arbiter arbiter_i (
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n_i),
    .m_cyc_i    ({m1_cyc_i, m0_cyc_i}),
    .grant_o    (grant),
    .bus_busy_o (bus_busy)
  );

  // Forward the granted master
  always_comb begin
    sl_cyc_o = 1'b0;
    gnt_stb  = 1'b0;
    sl_we_o  = 1'b0;
    sl_adr_o = '0;
    sl_dat_o = '0;
    sl_sel_o = '0;
    case (grant)
      2'b01: begin
        sl_cyc_o = m0_cyc_i;
        gnt_stb  = m0_stb_i;
        sl_we_o  = m0_we_i;
        sl_adr_o = m0_adr_i;
        sl_dat_o = m0_dat_i;
        sl_sel_o = m0_sel_i;
      end
      2'b10: begin
        sl_cyc_o = m1_cyc_i;
        gnt_stb  = m1_stb_i;
        sl_we_o  = m1_we_i;
        sl_adr_o = m1_adr_i;
        sl_dat_o = m1_dat_i;
        sl_sel_o = m1_sel_i;
      end
      default: ;
    endcase
  end

  assign hit[0] = in_window(sl_adr_o, RAM_BASE, RAM_SIZE);
  assign hit[1] = in_window(sl_adr_o, GPIO_BASE, GPIO_SIZE);
  assign hit[2] = in_window(sl_adr_o, RST_BASE, RST_SIZE);

  assign ram_stb_o  = bus_busy & sl_cyc_o & gnt_stb & hit[0];
  assign gpio_stb_o = bus_busy & sl_cyc_o & gnt_stb & hit[1];
  assign rst_stb_o  = bus_busy & sl_cyc_o & gnt_stb & hit[2];

  // Unmapped access gets err one cycle later, like a slave ack
  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_busy & sl_cyc_o & gnt_stb & ~|hit;
    end
  end

  assign ack_any = ram_ack_i | gpio_ack_i | rst_ack_i;

  always_comb begin
    if (ram_ack_i)       rd_dat = ram_dat_i;
    else if (gpio_ack_i) rd_dat = gpio_dat_i;
    else if (rst_ack_i)  rd_dat = rst_dat_i;
    else                 rd_dat = '0;
  end

  assign m0_stall_o = m0_cyc_i & ~grant[0];  // Idle master sees no stall
  assign m0_ack_o   = grant[0] & ack_any;
  assign m0_err_o   = grant[0] & err_q;
  assign m0_dat_o   = grant[0] ? rd_dat : '0;

  assign m1_stall_o = m1_cyc_i & ~grant[1];
  assign m1_ack_o   = grant[1] & ack_any;
  assign m1_err_o   = grant[1] & err_q;
  assign m1_dat_o   = grant[1] ? rd_dat : '0;

  a_one_slave: assert property (
    @(posedge sys_clk) disable iff (!rst_n_i)
    $onehot0({rst_stb_o, gpio_stb_o, ram_stb_o})
  );

endmodule

// ==== hdl/reset_seq.sv ====
module reset_seq import soc_pkg::*; (
  input  logic        sys_clk,
  input  logic        rst_n_i,
  input  logic        pll_locked_i,
  input  logic        ndm_req_i,
  output logic        dm_reset_o,
  output logic        ndm_reset_o,
  output logic        por_completed_o,
  output rst_reason_e reason_o
);

  logic [SYNC_STAGES-1:0]              rst_sync_q;
  logic [SYNC_STAGES-1:0]              lock_sync_q;
  logic                                src_bad;
  logic                                lock_fall;
  logic [$clog2(POR_CYCLES)-1:0]       por_cnt_q;
  logic                                dm_reset_q;
  logic [$clog2(NDM_PULSE_CYCLES)-1:0] ndm_cnt_q;
  logic                                ndm_act_q;
  rst_reason_e                         reason_q;

  // These flops are the reset source, so they have none themselves
  always_ff @(posedge sys_clk) begin
    rst_sync_q  <= {rst_sync_q[SYNC_STAGES-2:0], rst_n_i};
    lock_sync_q <= {lock_sync_q[SYNC_STAGES-2:0], pll_locked_i};
  end

  assign src_bad   = ~rst_n_i | ~rst_sync_q[SYNC_STAGES-1] | ~lock_sync_q[SYNC_STAGES-1];
  assign lock_fall = lock_sync_q[SYNC_STAGES-1] & ~lock_sync_q[SYNC_STAGES-2];

  // Power-on hold
  always_ff @(posedge sys_clk) begin
    if (src_bad) begin
      dm_reset_q <= 1'b1;
      por_cnt_q  <= '0;
    end else if (dm_reset_q) begin
      por_cnt_q <= por_cnt_q + 1'b1;
      if (por_cnt_q == POR_CYCLES - 1) dm_reset_q <= 1'b0;
    end
  end

  // Software requested non-debug reset pulse
  always_ff @(posedge sys_clk) begin
    if (dm_reset_q) begin
      ndm_act_q <= 1'b0;
      ndm_cnt_q <= '0;
    end else if (ndm_req_i) begin
      ndm_act_q <= 1'b1;
      ndm_cnt_q <= '0;
    end else if (ndm_act_q) begin
      ndm_cnt_q <= ndm_cnt_q + 1'b1;
      if (ndm_cnt_q == NDM_PULSE_CYCLES - 1) ndm_act_q <= 1'b0;
    end
  end

  // Last reset cause, survives every reset except a new event
  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      reason_q <= POWER_ON;
    end else if (rst_sync_q[SYNC_STAGES-1] && lock_fall) begin
      reason_q <= PLL_LOSS;
    end else if (ndm_req_i && !dm_reset_q) begin
      reason_q <= SOFTWARE;
    end
  end

  assign dm_reset_o      = dm_reset_q;
  assign ndm_reset_o     = dm_reset_q | ndm_act_q;
  assign por_completed_o = ~dm_reset_q;
  assign reason_o        = reason_q;

  // A request from the register block yields a full-length pulse
  a_ndm_pulse: assert property (
    @(posedge sys_clk)
    (ndm_req_i && !dm_reset_q) |=> ndm_reset_o [*NDM_PULSE_CYCLES]
  );

endmodule

// ==== hdl/reset_regs.sv ====
module reset_regs import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              dm_reset_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] dat_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o,
  output logic              ndm_req_o,
  input  logic              por_completed_i,
  input  rst_reason_e       reason_i
);

  rst_word_u   wr_word;
  rst_word_u   rd_word;
  logic        ack_q;
  logic        ndm_req_q;
  logic [DATA_W-1:0] dat_q;

  assign wr_word = dat_i;

  always_comb begin
    rd_word                  = '0;  // Reserved bits read zero
    rd_word.rd.por_completed = por_completed_i;
    rd_word.rd.reason        = reason_i;
  end

  always_ff @(posedge sys_clk) begin
    if (dm_reset_i) begin
      ack_q     <= 1'b0;
      ndm_req_q <= 1'b0;
    end else begin
      ack_q     <= stb_i;
      ndm_req_q <= stb_i & we_i & wr_word.wr.ndm_req;  // High during the ack cycle
    end
  end

  always_ff @(posedge sys_clk) begin
    if (stb_i) dat_q <= rd_word;
  end

  assign ack_o     = ack_q;
  assign dat_o     = dat_q;
  assign ndm_req_o = ndm_req_q;

endmodule

// ==== hdl/gpio_port.sv ====
module gpio_port import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              ndm_reset_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [1:0]        adr_i,   // Word offset
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]  sel_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o,
  input  logic [GPIO_W-1:0] gpio_in_i,
  output logic [GPIO_W-1:0] gpio_out_o,
  output logic [GPIO_W-1:0] gpio_oe_o
);

  logic [GPIO_W-1:0]                  out_q;
  logic [GPIO_W-1:0]                  oe_q;
  logic [SYNC_STAGES-1:0][GPIO_W-1:0] in_sync_q;
  logic                               ack_q;
  logic [DATA_W-1:0]                  dat_q;
  logic [GPIO_W-1:0]                  rd_val;

  always_ff @(posedge sys_clk) begin
    in_sync_q <= {in_sync_q[SYNC_STAGES-2:0], gpio_in_i};  // Pins are asynchronous
  end

  always_ff @(posedge sys_clk) begin
    if (ndm_reset_i) begin
      out_q <= '0;
      oe_q  <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
      if (stb_i && we_i && sel_i[0]) begin
        case (adr_i)
          2'd0: out_q <= dat_i[GPIO_W-1:0];
          2'd1: oe_q  <= dat_i[GPIO_W-1:0];
          default: ;  // Input and spare offsets ignore writes
        endcase
      end
    end
  end

  always_comb begin
    case (adr_i)
      2'd0:    rd_val = out_q;
      2'd1:    rd_val = oe_q;
      2'd2:    rd_val = in_sync_q[SYNC_STAGES-1];
      default: rd_val = '0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (stb_i) dat_q <= DATA_W'(rd_val);
  end

  assign ack_o      = ack_q;
  assign dat_o      = dat_q;
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = oe_q;

endmodule

// ==== hdl/scratch_ram.sv ====
module scratch_ram import soc_pkg::*; (
  input  logic                         sys_clk,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic [$clog2(RAM_WORDS)-1:0] adr_i,  // Word index
  input  logic [DATA_W-1:0]            dat_i,
  input  logic [SEL_W-1:0]             sel_i,
  output logic                         ack_o,
  output logic [DATA_W-1:0]            dat_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [DATA_W-1:0] dat_q;
  logic              ack_q;

  // Byte-lane writes
  always_ff @(posedge sys_clk) begin
    if (stb_i && we_i) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel_i[b]) mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
      end
    end
  end

  // Registered read, old contents on a write cycle
  always_ff @(posedge sys_clk) begin
    if (stb_i) dat_q <= mem[adr_i];
  end

  // Strobes stay low while the fabric is in reset, so this settles on its own
  always_ff @(posedge sys_clk) begin
    ack_q <= stb_i;
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

endmodule

// ==== hdl/soc_fabric_top.sv ====
module soc_fabric_top import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n_i,
  input  logic              pll_locked_i,
  input  logic              m0_cyc_i,
  input  logic              m0_stb_i,
  input  logic              m0_we_i,
  input  logic [ADDR_W-1:0] m0_adr_i,
  input  logic [DATA_W-1:0] m0_dat_i,
  input  logic [SEL_W-1:0]  m0_sel_i,
  output logic              m0_stall_o,
  output logic              m0_ack_o,
  output logic              m0_err_o,
  output logic [DATA_W-1:0] m0_dat_o,
  input  logic              m1_cyc_i,
  input  logic              m1_stb_i,
  input  logic              m1_we_i,
  input  logic [ADDR_W-1:0] m1_adr_i,
  input  logic [DATA_W-1:0] m1_dat_i,
  input  logic [SEL_W-1:0]  m1_sel_i,
  output logic              m1_stall_o,
  output logic              m1_ack_o,
  output logic              m1_err_o,
  output logic [DATA_W-1:0] m1_dat_o,
  input  logic [GPIO_W-1:0] gpio_in_i,
  output logic [GPIO_W-1:0] gpio_out_o,
  output logic [GPIO_W-1:0] gpio_oe_o,
  output logic              ndm_reset_o,
  output logic              por_completed_o
);

  logic              dm_reset;
  logic              ndm_reset;
  logic              ndm_req;
  rst_reason_e       reason;
  logic              sl_we;
  logic [ADDR_W-1:0] sl_adr;
  logic [DATA_W-1:0] sl_dat;
  logic [SEL_W-1:0]  sl_sel;
  logic              ram_stb, gpio_stb, rst_stb;
  logic              ram_ack, gpio_ack, rst_ack;
  logic [DATA_W-1:0] ram_dat, gpio_dat, rst_dat;

  shared_bus bus_i (
    .sys_clk (sys_clk), .rst_n_i (~dm_reset),
    .m0_cyc_i (m0_cyc_i), .m0_stb_i (m0_stb_i), .m0_we_i (m0_we_i),
    .m0_adr_i (m0_adr_i), .m0_dat_i (m0_dat_i), .m0_sel_i (m0_sel_i),
    .m0_stall_o (m0_stall_o), .m0_ack_o (m0_ack_o), .m0_err_o (m0_err_o),
    .m0_dat_o (m0_dat_o),
    .m1_cyc_i (m1_cyc_i), .m1_stb_i (m1_stb_i), .m1_we_i (m1_we_i),
    .m1_adr_i (m1_adr_i), .m1_dat_i (m1_dat_i), .m1_sel_i (m1_sel_i),
    .m1_stall_o (m1_stall_o), .m1_ack_o (m1_ack_o), .m1_err_o (m1_err_o),
    .m1_dat_o (m1_dat_o),
    .sl_cyc_o (), .sl_we_o (sl_we), .sl_adr_o (sl_adr), .sl_dat_o (sl_dat),
    .sl_sel_o (sl_sel),
    .ram_stb_o (ram_stb), .gpio_stb_o (gpio_stb), .rst_stb_o (rst_stb),
    .ram_ack_i (ram_ack), .ram_dat_i (ram_dat),
    .gpio_ack_i (gpio_ack), .gpio_dat_i (gpio_dat),
    .rst_ack_i (rst_ack), .rst_dat_i (rst_dat)
  );

  reset_seq reset_seq_i (
    .sys_clk (sys_clk), .rst_n_i (rst_n_i), .pll_locked_i (pll_locked_i),
    .ndm_req_i (ndm_req), .dm_reset_o (dm_reset), .ndm_reset_o (ndm_reset),
    .por_completed_o (por_completed_o), .reason_o (reason)
  );

  reset_regs reset_regs_i (
    .sys_clk (sys_clk), .dm_reset_i (dm_reset), .stb_i (rst_stb), .we_i (sl_we),
    .dat_i (sl_dat), .ack_o (rst_ack), .dat_o (rst_dat), .ndm_req_o (ndm_req),
    .por_completed_i (por_completed_o), .reason_i (reason)
  );

  gpio_port gpio_i (
    .sys_clk (sys_clk), .ndm_reset_i (ndm_reset), .stb_i (gpio_stb), .we_i (sl_we),
    .adr_i (sl_adr[3:2]), .dat_i (sl_dat), .sel_i (sl_sel), .ack_o (gpio_ack),
    .dat_o (gpio_dat), .gpio_in_i (gpio_in_i), .gpio_out_o (gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  scratch_ram ram_i (
    .sys_clk (sys_clk), .stb_i (ram_stb), .we_i (sl_we),
    .adr_i (sl_adr[$clog2(RAM_WORDS)+1:2]),  // Byte address to word index
    .dat_i (sl_dat), .sel_i (sl_sel), .ack_o (ram_ack), .dat_o (ram_dat)
  );

  assign ndm_reset_o = ndm_reset;

endmodule

// ==== test/tb_soc_fabric.sv ====
module tb_soc_fabric import soc_pkg::*; ();

  logic                   sys_clk;
  logic                   rst_n_i;
  logic                   pll_locked_i;
  logic [1:0]             m_cyc;
  logic [1:0]             m_stb;
  logic [1:0]             m_we;
  logic [1:0][ADDR_W-1:0] m_adr;
  logic [1:0][DATA_W-1:0] m_wdat;
  logic [1:0][SEL_W-1:0]  m_sel;
  wire  [1:0]             m_stall;
  wire  [1:0]             m_ack;
  wire  [1:0]             m_err;
  wire  [1:0][DATA_W-1:0] m_rdat;
  logic [GPIO_W-1:0]      gpio_in;
  wire  [GPIO_W-1:0]      gpio_out;
  wire  [GPIO_W-1:0]      gpio_oe;
  wire                    ndm_reset;
  wire                    por_completed;

  int                errors;
  int                checks;
  int                tests;
  int                wait_limit = 64;   // Bus wait limit in cycles
  logic [DATA_W-1:0] shadow [RAM_WORDS];  // Expected RAM contents

  soc_fabric_top dut_i (
    .sys_clk (sys_clk), .rst_n_i (rst_n_i), .pll_locked_i (pll_locked_i),
    .m0_cyc_i (m_cyc[0]), .m0_stb_i (m_stb[0]), .m0_we_i (m_we[0]), .m0_adr_i (m_adr[0]),
    .m0_dat_i (m_wdat[0]), .m0_sel_i (m_sel[0]), .m0_stall_o (m_stall[0]),
    .m0_ack_o (m_ack[0]), .m0_err_o (m_err[0]), .m0_dat_o (m_rdat[0]),
    .m1_cyc_i (m_cyc[1]), .m1_stb_i (m_stb[1]), .m1_we_i (m_we[1]), .m1_adr_i (m_adr[1]),
    .m1_dat_i (m_wdat[1]), .m1_sel_i (m_sel[1]), .m1_stall_o (m_stall[1]),
    .m1_ack_o (m_ack[1]), .m1_err_o (m_err[1]), .m1_dat_o (m_rdat[1]),
    .gpio_in_i (gpio_in), .gpio_out_o (gpio_out), .gpio_oe_o (gpio_oe),
    .ndm_reset_o (ndm_reset), .por_completed_o (por_completed)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic check_data(input string what, input logic [DATA_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input rst_word_u got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, por_completed %b reason %0d, expected %b %0d (word %h)",
               $time, what, got.rd.por_completed, got.rd.reason, exp.rd.por_completed,
               exp.rd.reason, got);
    end
  endtask

  task automatic check_gpio(input string what, input logic [GPIO_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, pins %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, err %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, level %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    if (errors == start) $display("%-14s ok", name);
    else $display("%-14s failed with %0d errors", name, errors - start);
  endtask

  function automatic logic [DATA_W-1:0] merge_lanes(logic [DATA_W-1:0] old_d,
                                                    logic [DATA_W-1:0] wdat,
                                                    logic [SEL_W-1:0] sel);
    logic [DATA_W-1:0] res;
    res = old_d;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) res[b*8 +: 8] = wdat[b*8 +: 8];
    end
    return res;
  endfunction

  // One transfer inside a cycle that is left open on return
  task automatic bus_access(input int m, input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel,
                            output logic [DATA_W-1:0] rdat, output logic err);
    int n;
    rdat = 'x;
    err  = 1'b0;
    @(posedge sys_clk);
    m_cyc[m]  <= 1'b1;
    m_stb[m]  <= 1'b1;
    m_we[m]   <= we;
    m_adr[m]  <= adr;
    m_wdat[m] <= wdat;
    m_sel[m]  <= sel;
    n = 0;
    @(negedge sys_clk);
    while (m_stall[m] && n < wait_limit) begin
      @(negedge sys_clk);
      n++;
    end
    if (m_stall[m]) report_timeout($sformatf("stall to clear on master %0d", m));
    @(posedge sys_clk);  // Accepted on this edge
    m_stb[m] <= 1'b0;
    n = 0;
    @(negedge sys_clk);
    while (!(m_ack[m] || m_err[m]) && n < wait_limit) begin
      @(negedge sys_clk);
      n++;
    end
    if (!(m_ack[m] || m_err[m])) begin
      report_timeout($sformatf("ack or err on master %0d", m));
    end
    rdat = m_rdat[m];
    err  = m_err[m];
  endtask

  task automatic release_bus(input int m);
    @(posedge sys_clk);
    m_cyc[m] <= 1'b0;
    m_we[m]  <= 1'b0;
  endtask

  task automatic wb_write(input int m, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel,
                          output logic err);
    logic [DATA_W-1:0] unused;
    bus_access(m, 1'b1, adr, wdat, sel, unused, err);
    release_bus(m);
  endtask

  task automatic wb_read(input int m, input logic [ADDR_W-1:0] adr,
                         output logic [DATA_W-1:0] rdat, output logic err);
    bus_access(m, 1'b0, adr, '0, '1, rdat, err);
    release_bus(m);
  endtask

  function automatic logic watched(bit pick_ndm);
    return pick_ndm ? ndm_reset : por_completed;
  endfunction

  task automatic wait_for_signal(input bit pick_ndm, input logic level, input int limit);
    int n;
    n = 0;
    @(negedge sys_clk);
    while (watched(pick_ndm) !== level && n < limit) begin
      @(negedge sys_clk);
      n++;
    end
    if (watched(pick_ndm) !== level) begin
      report_timeout($sformatf("%s to become %b", pick_ndm ? "ndm_reset_o" : "por_completed_o",
                               level));
    end
  endtask

  task automatic test_power_on();
    int                start;
    logic [DATA_W-1:0] rdat;
    logic              err;
    rst_word_u         exp;
    start = errors;
    wait_for_signal(1'b0, 1'b1, POR_CYCLES + 10);
    check_gpio("gpio_oe_o after reset", gpio_oe, '0);
    check_gpio("gpio_out_o after reset", gpio_out, '0);
    for (int m = 0; m < 2; m++) begin
      check_flag($sformatf("m%0d stall after reset", m), m_stall[m], 1'b0);
      check_flag($sformatf("m%0d ack after reset", m), m_ack[m], 1'b0);
      check_err($sformatf("m%0d err after reset", m), m_err[m], 1'b0);
    end
    wb_read(0, RST_BASE, rdat, err);
    check_err("reset word read", err, 1'b0);
    exp                  = '0;
    exp.rd.por_completed = 1'b1;
    exp.rd.reason        = POWER_ON;
    check_word("reset word after power-on", rdat, exp);
    report_test("power-on", start);
  endtask

  task automatic test_ram();
    int                start;
    int                idx;
    int                idx_q[$];
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;
    logic              err;
    start = errors;
    for (int i = 0; i < 16; i++) begin
      if (i % 2 == 0) begin
        idx = $urandom % RAM_WORDS;
        sel = '1;
      end else begin
        sel = SEL_W'($urandom_range(1, 14));  // Partial merge over the word just written
      end
      wdat = $urandom;
      wb_write(0, RAM_BASE + idx * SEL_W, wdat, sel, err);
      check_err("RAM write on m0", err, 1'b0);
      shadow[idx] = merge_lanes(shadow[idx], wdat, sel);
      idx_q.push_back(idx);
    end
    foreach (idx_q[i]) begin
      wb_read(1, RAM_BASE + idx_q[i] * SEL_W, rdat, err);
      check_err("RAM read on m1", err, 1'b0);
      check_data($sformatf("RAM word %0d", idx_q[i]), rdat, shadow[idx_q[i]]);
    end
    report_test("ram", start);
  endtask

  task automatic test_gpio();
    int                start;
    int                n;
    logic [GPIO_W-1:0] pins;
    logic [DATA_W-1:0] rdat;
    logic              err;
    start = errors;
    wb_write(0, GPIO_BASE, 32'h0000_00a5, 4'h1, err);
    check_err("GPIO output write", err, 1'b0);
    wb_write(0, GPIO_BASE, 32'h0000_005a, 4'he, err);  // Lane 0 off so nothing changes
    wb_write(0, GPIO_BASE + 4, 32'h0000_003c, 4'hf, err);
    check_gpio("gpio_out_o", gpio_out, 8'ha5);
    check_gpio("gpio_oe_o", gpio_oe, 8'h3c);
    wb_read(0, GPIO_BASE, rdat, err);
    check_data("GPIO output register", rdat, 32'h0000_00a5);
    wb_read(0, GPIO_BASE + 12, rdat, err);
    check_data("GPIO spare register", rdat, '0);
    pins = GPIO_W'($urandom);
    @(posedge sys_clk);
    gpio_in <= pins;
    n = 0;
    do begin
      wb_read(0, GPIO_BASE + 8, rdat, err);
      n++;
    end while (rdat[GPIO_W-1:0] !== pins && n < 8);
    if (rdat[GPIO_W-1:0] !== pins) report_timeout("GPIO input register to follow the pins");
    check_gpio("GPIO input register", rdat[GPIO_W-1:0], pins);
    report_test("gpio", start);
  endtask

  task automatic test_decode_err();
    int                start;
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;
    logic              err;
    start = errors;
    wb_read(0, 32'h2000_0000, rdat, err);
    check_err("read of 0x20000000", err, 1'b1);
    wb_write(0, 32'h2000_0000, $urandom, '1, err);
    check_err("write to 0x20000000", err, 1'b1);
    wb_read(1, RAM_BASE + RAM_SIZE, rdat, err);
    check_err("read just past RAM", err, 1'b1);
    wb_write(1, RAM_BASE + RAM_SIZE, $urandom, '1, err);
    check_err("write just past RAM", err, 1'b1);
    wdat = $urandom;
    wb_write(0, RAM_BASE + 7 * SEL_W, wdat, '1, err);
    check_err("RAM write after errors", err, 1'b0);
    shadow[7] = wdat;
    wb_read(0, RAM_BASE + 7 * SEL_W, rdat, err);
    check_err("RAM read after errors", err, 1'b0);
    check_data("RAM word 7 after errors", rdat, shadow[7]);
    report_test("decode-error", start);
  endtask

  task automatic test_arbitration();
    int                start;
    int                m0_done;
    int                m0_done_at_m1;
    logic [DATA_W-1:0] wdat [4];
    logic [DATA_W-1:0] rdat [4];
    logic              err0 [4];
    logic              err1 [4];
    logic [DATA_W-1:0] unused;
    start         = errors;
    m0_done       = 0;
    m0_done_at_m1 = -1;
    foreach (wdat[i]) wdat[i] = $urandom;
    fork
      begin
        for (int i = 0; i < 4; i++) begin
          bus_access(0, 1'b1, RAM_BASE + (100 + i) * SEL_W, wdat[i], '1, unused, err0[i]);
          if (i == 0) check_flag("m1 stall while m0 holds the bus", m_stall[1], 1'b1);
          m0_done++;
        end
        release_bus(0);
      end
      begin
        for (int i = 0; i < 4; i++) begin
          bus_access(1, 1'b0, RAM_BASE + (100 + i) * SEL_W, '0, '1, rdat[i], err1[i]);
          if (i == 0) m0_done_at_m1 = m0_done;
        end
        release_bus(1);
      end
    join
    check_data("m0 transfers done at m1 first ack", m0_done_at_m1, 4);
    for (int i = 0; i < 4; i++) begin
      shadow[100 + i] = wdat[i];
      check_err("m0 write during contention", err0[i], 1'b0);
      check_err("m1 read during contention", err1[i], 1'b0);
      check_data($sformatf("m1 read of word %0d", 100 + i), rdat[i], shadow[100 + i]);
    end
    report_test("arbitration", start);
  endtask

  task automatic test_sw_reset();
    int                start;
    logic [DATA_W-1:0] rdat;
    logic              err;
    rst_word_u         req;
    rst_word_u         exp;
    start         = errors;
    req           = '0;
    req.wr.ndm_req = 1'b1;
    wb_write(0, RST_BASE, req, '1, err);
    check_err("reset request write", err, 1'b0);
    wait_for_signal(1'b1, 1'b1, 10);
    @(negedge sys_clk);  // GPIO registers clear on the edge after ndm_reset_o rises
    check_gpio("gpio_out_o during software reset", gpio_out, '0);
    check_gpio("gpio_oe_o during software reset", gpio_oe, '0);
    wait_for_signal(1'b1, 1'b0, NDM_PULSE_CYCLES + 10);
    exp                  = '0;
    exp.rd.por_completed = 1'b1;
    exp.rd.reason        = SOFTWARE;
    wb_read(0, RST_BASE, rdat, err);
    check_word("reset word after software reset", rdat, exp);
    wb_read(1, RAM_BASE + 100 * SEL_W, rdat, err);
    check_data("RAM word 100 kept over software reset", rdat, shadow[100]);
    // Lose and regain PLL lock
    @(posedge sys_clk);
    pll_locked_i <= 1'b0;
    wait_for_signal(1'b0, 1'b0, 10);
    @(posedge sys_clk);
    pll_locked_i <= 1'b1;
    wait_for_signal(1'b0, 1'b1, POR_CYCLES + 10);
    exp.rd.reason = PLL_LOSS;
    wb_read(0, RST_BASE, rdat, err);
    check_word("reset word after PLL loss", rdat, exp);
    report_test("software-reset", start);
  endtask

  initial begin
    void'($urandom(60437));
    errors       = 0;
    checks       = 0;
    tests        = 0;
    rst_n_i      = 1'b0;
    pll_locked_i = 1'b1;
    m_cyc        = '0;
    m_stb        = '0;
    m_we         = '0;
    m_adr        = '0;
    m_wdat       = '0;
    m_sel        = '0;
    gpio_in      = '0;
    repeat (10) @(posedge sys_clk);
    rst_n_i <= 1'b1;
    test_power_on();
    test_ram();
    test_gpio();
    test_decode_err();
    test_arbitration();
    test_sw_reset();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== soc_fabric.f ====
hdl/soc_pkg.sv
hdl/bus_arbiter.sv
hdl/shared_bus.sv
hdl/reset_seq.sv
hdl/reset_regs.sv
hdl/gpio_port.sv
hdl/scratch_ram.sv
hdl/soc_fabric_top.sv
test/tb_soc_fabric.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - hdl/soc_pkg.sv
  - hdl/bus_arbiter.sv
  - hdl/shared_bus.sv
  - hdl/reset_seq.sv
  - hdl/reset_regs.sv
  - hdl/gpio_port.sv
  - hdl/scratch_ram.sv
  - hdl/soc_fabric_top.sv
  - target: test
    files:
      - test/tb_soc_fabric.sv
